// ==== common/rpPkg.sv ====
`default_nettype none

package rpPkg;

   ////////////////////////////////////////////////////////////
   // Drive geometry
   ////////////////////////////////////////////////////////////

   localparam int sectorW = 6;
   localparam int trackW = 6;
   localparam int cylW = 10;

   // Highest valid address of each field
   localparam logic [sectorW-1:0] lastSector = 6'd21;
   localparam logic [trackW-1:0] lastTrack = 6'd18;
   localparam logic [cylW-1:0] lastCyl = 10'd814;

   // Busy time, counted in clocks with dry low
   localparam int busyCntW = 6;
   localparam logic [busyCntW-1:0] sectorCycles = 6'd40;
   localparam logic [busyCntW-1:0] seekCycles = 6'd8;

   // Controller states
   localparam logic [1:0] stIdle = 2'd0;
   localparam logic [1:0] stBusy = 2'd1;
   localparam logic [1:0] stFinish = 2'd2;

   ////////////////////////////////////////////////////////////
   // Register map and function codes
   ////////////////////////////////////////////////////////////

   localparam logic [2:0] regCs1 = 3'd0;
   localparam logic [2:0] regDs = 3'd1;
   localparam logic [2:0] regEr1 = 3'd2;
   localparam logic [2:0] regDa = 3'd5;
   localparam logic [2:0] regDc = 3'd6;

   // Function field of CS1, GO bit excluded
   localparam logic [4:0] funNop = 5'o00;
   localparam logic [4:0] funSeek = 5'o02;
   localparam logic [4:0] funClear = 5'o04;
   localparam logic [4:0] funWrite = 5'o30;
   localparam logic [4:0] funRead = 5'o34;

   // ER1 bits set by drive events
   localparam int er1Ilf = 0;
   localparam int er1Ilr = 1;
   localparam int er1Rmr = 2;
   localparam int er1Aoe = 9;
   localparam int er1Iae = 10;
   localparam int er1Wle = 11;

   // DS bits
   localparam int dsDry = 7;
   localparam int dsWrl = 11;
   localparam int dsErr = 14;

   // One host word, seen as CS1 or as DA
   typedef union packed {
      struct packed {
         logic [9:0] unused;
         logic [4:0] fun;
         logic       go;
      } cs1;
      struct packed {
         logic [1:0]         unused;
         logic [trackW-1:0]  track;
         logic [1:0]         gap;
         logic [sectorW-1:0] sector;
      } da;
   } rpWord;

endpackage

`default_nettype wire

// ==== rtl/rpHostPort.sv ====
`timescale 1ns/100ps
`default_nettype none

module rpHostPort
(
   input  wire               clk,
   input  wire               rst,
   input  wire               hostValid,
   output logic              hostReady,
   input  wire               hostWrite,
   input  wire  [2:0]        hostAddr,
   input  wire  rpPkg::rpWord hostWdata,
   output logic              hostRvalid,
   output logic [15:0]       hostRdata,
   input  wire               dry,
   input  wire  [15:0]       ds,
   input  wire  [15:0]       er1,
   input  wire  [15:0]       da,
   input  wire  [rpPkg::cylW-1:0] dcCyl,
   output logic              cs1Wr,
   output logic              daWr,
   output logic              dcWr,
   output logic              er1Wr,
   output logic [15:0]       wdata,
   output logic              rmrSet,
   output logic              ilrSet,
   output logic [4:0]        funCode
);

   import rpPkg::*;

   logic        rspPending;
   logic        accept;
   logic        wrAcc;
   logic        regWritable;
   logic [15:0] rdNext;
   rpWord       cs1Rd;

   ////////////////////////////////////////////////////////////
   // Request handshake
   ////////////////////////////////////////////////////////////

   // No new request while a read response is out
   assign hostReady = !rspPending;
   assign accept = hostValid & hostReady;
   assign wrAcc = accept & hostWrite;

   // Host-writable drive registers
   assign regWritable = (hostAddr == regCs1) || (hostAddr == regDa) ||
                        (hostAddr == regDc) || (hostAddr == regEr1);

   // Strobes only while the drive is ready
   assign cs1Wr = wrAcc & dry & (hostAddr == regCs1);
   assign daWr = wrAcc & dry & (hostAddr == regDa);
   assign dcWr = wrAcc & dry & (hostAddr == regDc);
   assign er1Wr = wrAcc & dry & (hostAddr == regEr1);

   // Busy drive refuses the write
   assign rmrSet = wrAcc & !dry & regWritable;
   // DS or a hole in the map
   assign ilrSet = wrAcc & !regWritable;

   assign wdata = hostWdata;
   assign funCode = hostWdata.cs1.fun;

   ////////////////////////////////////////////////////////////
   // Read data
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      // GO reads back as set while a function runs
      cs1Rd = '0;
      cs1Rd.cs1.go = !dry;
      case (hostAddr)
         regCs1: rdNext = cs1Rd;
         regDs: rdNext = ds;
         regEr1: rdNext = er1;
         regDa: rdNext = da;
         regDc: rdNext = {{(16 - cylW){1'b0}}, dcCyl};
         default: rdNext = '0;
      endcase
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         rspPending <= 1'b0;
      else
         rspPending <= accept & !hostWrite;
   end

   // Response word, one cycle after the read is taken
   always_ff @(posedge clk)
   begin
      if (accept && !hostWrite)
         hostRdata <= rdNext;
   end

   assign hostRvalid = rspPending;

   // Drive goes busy only through a CS1 write passed on here
   aBusyAfterCs1: assert property (@(posedge clk) disable iff (rst)
      $fell(dry) |-> $past(cs1Wr));

endmodule

`default_nettype wire

// ==== drive/rpDriveCtrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module rpDriveCtrl
(
   input  wire                    clk,
   input  wire                    rst,
   input  wire                    cs1Wr,
   input  wire  [4:0]             funCode,
   input  wire                    go,
   input  wire                    writeLock,
   input  wire  [15:0]            da,
   input  wire  [rpPkg::cylW-1:0] dcCyl,
   input  wire                    er1Any,
   output logic                   dry,
   output logic [15:0]            ds,
   output logic                   ilfSet,
   output logic                   iaeSet,
   output logic                   wleSet,
   output logic                   driveClr,
   output logic                   incSector
);

   import rpPkg::*;

   logic [1:0]          state;
   logic [busyCntW-1:0] busyCnt;
   logic                xferOp;
   logic                start;
   logic                isSeek;
   logic                isXfer;
   logic                funLegal;
   logic                addrOk;
   logic                wrLocked;
   logic                runOp;
   rpWord               daView;

   ////////////////////////////////////////////////////////////
   // Function decode and checks
   ////////////////////////////////////////////////////////////

   assign daView = da;

   // GO bit of a CS1 write starts the function
   assign start = cs1Wr & go;

   assign isSeek = (funCode == funSeek);
   assign isXfer = (funCode == funRead) || (funCode == funWrite);
   assign funLegal = (funCode == funNop) || (funCode == funClear) || isSeek || isXfer;

   // Address against geometry
   assign addrOk = (daView.da.sector <= lastSector) && (daView.da.track <= lastTrack) &&
                   (dcCyl <= lastCyl);
   assign wrLocked = (funCode == funWrite) & writeLock;

   // Error pulses in the GO cycle, ER1 takes them on the next edge
   assign ilfSet = start & !funLegal;
   assign driveClr = start & (funCode == funClear);
   assign iaeSet = start & (isSeek | isXfer) & !addrOk;
   assign wleSet = start & addrOk & wrLocked;

   assign runOp = start & (isSeek | isXfer) & addrOk & !wrLocked;

   ////////////////////////////////////////////////////////////
   // State machine
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= stIdle;
         busyCnt <= '0;
         xferOp <= 1'b0;
      end
      else
      begin
         case (state)
            stIdle:
            begin
               if (runOp)
               begin
                  // Busy plus finish make up the full time
                  state <= stBusy;
                  busyCnt <= (isSeek ? seekCycles : sectorCycles) - busyCntW'(2);
                  xferOp <= isXfer;
               end
            end
            stBusy:
            begin
               if (busyCnt == '0)
                  state <= stFinish;
               else
                  busyCnt <= busyCnt - 1'b1;
            end
            default:
               state <= stIdle;
         endcase
      end
   end

   assign dry = (state == stIdle);
   // One sector moved, step the address
   assign incSector = (state == stFinish) & xferOp;

   always_comb
   begin
      ds = '0;
      ds[dsDry] = dry;
      ds[dsWrl] = writeLock;
      ds[dsErr] = er1Any;
   end

   // Step exactly one sector time after its GO
   aIncAfterSector: assert property (@(posedge clk) disable iff (rst)
      incSector |-> $past(start, sectorCycles));

endmodule

`default_nettype wire

// ==== drive/rpAddrRegs.sv ====
`timescale 1ns/100ps
`default_nettype none

module rpAddrRegs
(
   input  wire                    clk,
   input  wire                    rst,
   input  wire                    daWr,
   input  wire                    dcWr,
   input  wire  [15:0]            wdata,
   input  wire                    incSector,
   output logic [15:0]            da,
   output logic [rpPkg::cylW-1:0] dcCyl,
   output logic                   aoeSet
);

   import rpPkg::*;

   logic [sectorW-1:0] sector;
   logic [trackW-1:0]  track;
   logic               sectorLast;
   logic               trackLast;
   logic               cylLast;
   rpWord              wrView;
   rpWord              daView;

   assign wrView = wdata;

   assign sectorLast = (sector == lastSector);
   assign trackLast = (track == lastTrack);
   assign cylLast = (dcCyl == lastCyl);

   // Stepping past the last block of the pack
   assign aoeSet = incSector & sectorLast & trackLast & cylLast;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         sector <= '0;
         track <= '0;
         dcCyl <= '0;
      end
      else if (incSector)
      begin
         // Sector, then track, then cylinder
         if (!sectorLast)
            sector <= sector + 1'b1;
         else
         begin
            sector <= '0;
            if (!trackLast)
               track <= track + 1'b1;
            else
            begin
               track <= '0;
               dcCyl <= cylLast ? '0 : dcCyl + 1'b1;
            end
         end
      end
      else
      begin
         if (daWr)
         begin
            sector <= wrView.da.sector;
            track <= wrView.da.track;
         end
         if (dcWr)
            dcCyl <= wdata[cylW-1:0];
      end
   end

   // Unused DA bits read as zero
   always_comb
   begin
      daView = '0;
      daView.da.sector = sector;
      daView.da.track = track;
   end

   assign da = daView;

endmodule

`default_nettype wire

// ==== drive/rpErr1.sv ====
`timescale 1ns/100ps
`default_nettype none

module rpErr1
(
   input  wire         clk,
   input  wire         rst,
   input  wire         driveClr,
   input  wire         er1Wr,
   input  wire  [15:0] wdata,
   input  wire         ilfSet,
   input  wire         ilrSet,
   input  wire         rmrSet,
   input  wire         aoeSet,
   input  wire         iaeSet,
   input  wire         wleSet,
   output logic [15:0] er1,
   output logic        er1Any
);

   import rpPkg::*;

   logic [15:0] evt;

   ////////////////////////////////////////////////////////////
   // Event pulses mapped onto ER1 bits
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      evt = '0;
      // Bad function code
      evt[er1Ilf] = ilfSet;
      // Write to DS or an unused address
      evt[er1Ilr] = ilrSet;
      // Write refused, drive busy
      evt[er1Rmr] = rmrSet;
      // Ran off the end of the pack
      evt[er1Aoe] = aoeSet;
      // Start with a bad disk address
      evt[er1Iae] = iaeSet;
      // Write with the pack locked
      evt[er1Wle] = wleSet;
   end

   ////////////////////////////////////////////////////////////
   // Sticky register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         er1 <= '0;
      else if (driveClr)
         er1 <= '0;
      else if (er1Wr)
         er1 <= wdata;
      else
         er1 <= er1 | evt;
   end

   // Feeds the ERR bit of DS
   assign er1Any = |er1;

   // Clear comes from a CS1 write, so it cannot meet an ER1 write
   aClrVsWrite: assert property (@(posedge clk) disable iff (rst)
      !(driveClr && er1Wr));

endmodule

`default_nettype wire

// ==== rtl/rpDrive.sv ====
`timescale 1ns/100ps
`default_nettype none

module rpDrive
(
   input  wire               clk,
   input  wire               rst,
   input  wire               writeLock,
   input  wire               hostValid,
   output logic              hostReady,
   input  wire               hostWrite,
   input  wire  [2:0]        hostAddr,
   input  wire  rpPkg::rpWord hostWdata,
   output logic              hostRvalid,
   output logic [15:0]       hostRdata
);

   import rpPkg::*;

   logic              cs1Wr;
   logic              daWr;
   logic              dcWr;
   logic              er1Wr;
   logic [15:0]       wdata;
   logic              rmrSet;
   logic              ilrSet;
   logic [4:0]        funCode;
   logic              dry;
   logic [15:0]       ds;
   logic [15:0]       er1;
   logic              er1Any;
   logic [15:0]       da;
   logic [cylW-1:0]   dcCyl;
   logic              ilfSet;
   logic              iaeSet;
   logic              wleSet;
   logic              aoeSet;
   logic              driveClr;
   logic              incSector;
   rpWord             cs1View;

   // GO bit of the written word
   assign cs1View = wdata;

   ////////////////////////////////////////////////////////////
   // Host port, controller and registers
   ////////////////////////////////////////////////////////////

   rpHostPort uHost (
      .clk(clk), .rst(rst), .hostValid(hostValid), .hostReady(hostReady),
      .hostWrite(hostWrite), .hostAddr(hostAddr), .hostWdata(hostWdata),
      .hostRvalid(hostRvalid), .hostRdata(hostRdata), .dry(dry), .ds(ds),
      .er1(er1), .da(da), .dcCyl(dcCyl), .cs1Wr(cs1Wr), .daWr(daWr),
      .dcWr(dcWr), .er1Wr(er1Wr), .wdata(wdata), .rmrSet(rmrSet),
      .ilrSet(ilrSet), .funCode(funCode));

   rpDriveCtrl uCtrl (
      .clk(clk), .rst(rst), .cs1Wr(cs1Wr), .funCode(funCode), .go(cs1View.cs1.go),
      .writeLock(writeLock), .da(da), .dcCyl(dcCyl), .er1Any(er1Any), .dry(dry),
      .ds(ds), .ilfSet(ilfSet), .iaeSet(iaeSet), .wleSet(wleSet),
      .driveClr(driveClr), .incSector(incSector));

   rpAddrRegs uAddr (
      .clk(clk), .rst(rst), .daWr(daWr), .dcWr(dcWr), .wdata(wdata),
      .incSector(incSector), .da(da), .dcCyl(dcCyl), .aoeSet(aoeSet));

   rpErr1 uErr1 (
      .clk(clk), .rst(rst), .driveClr(driveClr), .er1Wr(er1Wr), .wdata(wdata),
      .ilfSet(ilfSet), .ilrSet(ilrSet), .rmrSet(rmrSet), .aoeSet(aoeSet),
      .iaeSet(iaeSet), .wleSet(wleSet), .er1(er1), .er1Any(er1Any));

endmodule

`default_nettype wire

// ==== tb/rpDriveChecker.sv ====
`timescale 1ns/100ps
`default_nettype none

module rpDriveChecker
(
   input  wire         clk,
   input  wire         rst,
   input  wire         writeLock,
   input  wire         hostValid,
   input  wire         hostReady,
   input  wire         hostWrite,
   input  wire  [2:0]  hostAddr,
   input  wire  [15:0] hostWdata,
   input  wire         hostRvalid,
   input  wire  [15:0] hostRdata,
   output int          checkCount,
   output int          errorCount
);

   import rpPkg::*;

   // Reference registers, valid between two rising edges
   logic [15:0]        er1M;
   logic [sectorW-1:0] sectorM;
   logic [trackW-1:0]  trackM;
   logic [cylW-1:0]    cylM;
   int                 busyLeft;
   logic               xferM;

   // Read taken on the coming edge, answered one cycle later
   logic               rspDue;
   logic [2:0]         rspAddr;
   logic [15:0]        rspExp;

   // Per-edge scratch
   logic [15:0]        evt;
   logic               clrM;
   logic               wrM;
   logic               dryM;
   logic               readyM;
   logic               stepNow;
   rpWord              wv;

   ////////////////////////////////////////////////////////////
   // Reference functions
   ////////////////////////////////////////////////////////////

   // Clear wins, then a host write, else events stick
   function automatic logic [15:0] predictER1(input logic [15:0] cur, input logic clr,
      input logic wr, input logic [15:0] data, input logic [15:0] events);
      if (clr)
         return '0;
      if (wr)
         return data;
      return cur | events;
   endfunction

   function automatic logic [15:0] predictRead(input logic [2:0] addr);
      logic [15:0] v;
      rpWord       w;
      v = '0;
      w = '0;
      case (addr)
         // GO still set while busy
         regCs1: v[0] = (busyLeft != 0);
         regDs:
         begin
            v[dsDry] = (busyLeft == 0);
            v[dsWrl] = writeLock;
            v[dsErr] = |er1M;
         end
         regEr1: v = er1M;
         regDa:
         begin
            w.da.track = trackM;
            w.da.sector = sectorM;
            v = w;
         end
         regDc: v[cylW-1:0] = cylM;
         default: v = '0;
      endcase
      return v;
   endfunction

   function automatic string regName(input logic [2:0] addr);
      case (addr)
         regCs1: return "CS1";
         regDs: return "DS";
         regEr1: return "ER1";
         regDa: return "DA";
         regDc: return "DC";
         default: return "unmapped";
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Compare and update, half a cycle before each rising edge
   ////////////////////////////////////////////////////////////

   always @(negedge clk)
   begin
      if (rst)
      begin
         er1M = '0;
         sectorM = '0;
         trackM = '0;
         cylM = '0;
         busyLeft = 0;
         xferM = 1'b0;
         rspDue = 1'b0;
         checkCount = 0;
         errorCount = 0;
      end
      else
      begin
         // Port is busy only in the response cycle
         readyM = !rspDue;
         if (hostReady !== readyM)
         begin
            $display("FAILED at %0t: hostReady expected %b, got %b",
                     $time, readyM, hostReady);
            errorCount++;
         end

         // Response to the read taken on the last edge
         if (rspDue)
         begin
            checkCount++;
            if (!hostRvalid)
            begin
               $display("Read of %s at %0t got no response", regName(rspAddr), $time);
               errorCount++;
            end
            else if (hostRdata !== rspExp)
            begin
               $display("FAILED at %0t: hostRdata (%s) expected %h, got %h",
                        $time, regName(rspAddr), rspExp, hostRdata);
               errorCount++;
            end
         end
         else if (hostRvalid)
         begin
            $display("Read response at %0t came without a read request", $time);
            errorCount++;
         end

         rspDue = 1'b0;
         evt = '0;
         clrM = 1'b0;
         wrM = 1'b0;
         dryM = (busyLeft == 0);
         wv = hostWdata;

         if (hostValid && readyM && !hostWrite)
         begin
            rspDue = 1'b1;
            rspAddr = hostAddr;
            rspExp = predictRead(hostAddr);
         end

         // Busy time runs out on this edge
         stepNow = 1'b0;
         if (busyLeft != 0)
         begin
            busyLeft--;
            stepNow = (busyLeft == 0) && xferM;
         end

         // One sector done, sector then track then cylinder
         if (stepNow)
         begin
            if (sectorM != lastSector)
               sectorM = sectorM + sectorW'(1);
            else
            begin
               sectorM = '0;
               if (trackM != lastTrack)
                  trackM = trackM + trackW'(1);
               else
               begin
                  trackM = '0;
                  if (cylM != lastCyl)
                     cylM = cylM + cylW'(1);
                  else
                  begin
                     cylM = '0;
                     evt[er1Aoe] = 1'b1;
                  end
               end
            end
         end

         if (hostValid && readyM && hostWrite)
         begin
            if (!(hostAddr inside {regCs1, regDa, regDc, regEr1}))
               evt[er1Ilr] = 1'b1;
            else if (!dryM)
               evt[er1Rmr] = 1'b1;
            else
            begin
               case (hostAddr)
                  regEr1: wrM = 1'b1;
                  regDa:
                  begin
                     sectorM = wv.da.sector;
                     trackM = wv.da.track;
                  end
                  regDc: cylM = hostWdata[cylW-1:0];
                  default:
                  begin
                     // CS1, acts only with GO
                     if (wv.cs1.go)
                     begin
                        case (wv.cs1.fun)
                           funNop: clrM = 1'b0;
                           funClear: clrM = 1'b1;
                           funSeek, funRead, funWrite:
                           begin
                              if (sectorM > lastSector || trackM > lastTrack ||
                                  cylM > lastCyl)
                                 evt[er1Iae] = 1'b1;
                              else if (wv.cs1.fun == funWrite && writeLock)
                                 evt[er1Wle] = 1'b1;
                              else
                              begin
                                 xferM = (wv.cs1.fun != funSeek);
                                 busyLeft = xferM ? int'(sectorCycles) : int'(seekCycles);
                              end
                           end
                           default: evt[er1Ilf] = 1'b1;
                        endcase
                     end
                  end
               endcase
            end
         end

         er1M = predictER1(er1M, clrM, wrM, hostWdata, evt);
      end
   end

endmodule

`default_nettype wire

// ==== tb/rpDriveTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rpDriveTb;

   import rpPkg::*;

   // Cycles a handshake may take
   localparam int handshakeLimit = 20;
   // DS reads while waiting for a function to end
   localparam int pollLimit = 60;

   logic        clk;
   logic        rst;
   logic        writeLock;
   logic        hostValid;
   logic        hostReady;
   logic        hostWrite;
   logic [2:0]  hostAddr;
   logic [15:0] hostWdata;
   logic        hostRvalid;
   logic [15:0] hostRdata;

   int          checks;
   int          errors;
   int          timeouts;
   int          seed;
   int          i;
   logic [31:0] r;
   logic [15:0] d;
   logic [sectorW-1:0] sec;
   logic [trackW-1:0]  trk;
   logic [cylW-1:0]    cyl;

   rpDrive DUT (
      .clk(clk), .rst(rst), .writeLock(writeLock), .hostValid(hostValid),
      .hostReady(hostReady), .hostWrite(hostWrite), .hostAddr(hostAddr),
      .hostWdata(hostWdata), .hostRvalid(hostRvalid), .hostRdata(hostRdata));

   rpDriveChecker uCheck (
      .clk(clk), .rst(rst), .writeLock(writeLock), .hostValid(hostValid),
      .hostReady(hostReady), .hostWrite(hostWrite), .hostAddr(hostAddr),
      .hostWdata(hostWdata), .hostRvalid(hostRvalid), .hostRdata(hostRdata),
      .checkCount(checks), .errorCount(errors));

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Host access tasks, entered 5 ns after a rising edge
   ////////////////////////////////////////////////////////////

   task automatic offerRequest(input logic wr, input logic [2:0] addr, input logic [15:0] data);
      int n;
      n = 0;
      hostValid = 1'b1;
      hostWrite = wr;
      hostAddr = addr;
      hostWdata = data;
      while (!hostReady && n < handshakeLimit)
      begin
         @(posedge clk);
         #5;
         n++;
      end
      if (!hostReady)
      begin
         $display("Timeout: host port never became ready at %0t", $time);
         timeouts++;
      end
      // Taken on this edge
      @(posedge clk);
      #5;
      hostValid = 1'b0;
      hostWrite = 1'b0;
   endtask

   task automatic regWrite(input logic [2:0] addr, input logic [15:0] data);
      offerRequest(1'b1, addr, data);
   endtask

   task automatic regRead(input logic [2:0] addr, output logic [15:0] data);
      int n;
      n = 0;
      offerRequest(1'b0, addr, 16'h0000);
      while (!hostRvalid && n < handshakeLimit)
      begin
         @(posedge clk);
         #5;
         n++;
      end
      if (!hostRvalid)
      begin
         $display("Timeout: no read response at %0t", $time);
         timeouts++;
      end
      data = hostRdata;
   endtask

   // Poll DS until the drive is ready again
   task automatic waitReady();
      logic [15:0] st;
      int polls;
      st = '0;
      polls = 0;
      while (!st[dsDry] && polls < pollLimit)
      begin
         regRead(regDs, st);
         polls++;
      end
      if (!st[dsDry])
      begin
         $display("Timeout: drive still busy after %0d status polls", polls);
         timeouts++;
      end
   endtask

   function automatic logic [15:0] packDa(input logic [trackW-1:0] t,
      input logic [sectorW-1:0] s);
      rpWord w;
      w = '0;
      w.da.track = t;
      w.da.sector = s;
      return w;
   endfunction

   function automatic logic [15:0] goWord(input logic [4:0] fun);
      rpWord w;
      w = '0;
      w.cs1.fun = fun;
      w.cs1.go = 1'b1;
      return w;
   endfunction

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial
   begin
      seed = 32'h2a60;
      timeouts = 0;
      rst = 1'b1;
      writeLock = 1'b0;
      hostValid = 1'b0;
      hostWrite = 1'b0;
      hostAddr = '0;
      hostWdata = '0;
      repeat (10) @(posedge clk);
      #5;
      rst = 1'b0;

      // Register readback, then clear ER1
      for (i = 0; i < 4; i++)
      begin
         r = $random(seed);
         regWrite(regEr1, r[15:0]);
         regWrite(regDa, r[31:16]);
         regWrite(regDc, {r[7:0], r[31:24]});
         regRead(regEr1, d);
         regRead(regDa, d);
         regRead(regDc, d);
         regRead(regDs, d);
      end
      regWrite(regCs1, goWord(funClear));
      regRead(regEr1, d);
      regRead(regDs, d);

      // Illegal function, write to DS and to a hole
      regWrite(regCs1, goWord(5'o37));
      regRead(regEr1, d);
      regWrite(regDs, 16'hffff);
      regWrite(3'd3, 16'h1234);
      regRead(regEr1, d);
      regRead(3'd7, d);
      regWrite(regCs1, goWord(funClear));

      // Seek past the last cylinder
      regWrite(regDa, packDa(6'd2, 6'd4));
      regWrite(regDc, 16'd900);
      regWrite(regCs1, goWord(funSeek));
      regRead(regEr1, d);
      // Write on a locked pack
      regWrite(regDc, 16'd12);
      writeLock = 1'b1;
      regWrite(regCs1, goWord(funWrite));
      regRead(regDs, d);
      regRead(regEr1, d);
      writeLock = 1'b0;
      regWrite(regCs1, goWord(funClear));
      // Good seek, address stays put
      regWrite(regCs1, goWord(funSeek));
      regRead(regCs1, d);
      waitReady();
      regRead(regDa, d);
      regRead(regDc, d);

      // DA write during a busy read is refused
      regWrite(regDa, packDa(6'd5, 6'd3));
      regWrite(regDc, 16'd100);
      regWrite(regCs1, goWord(funRead));
      regWrite(regDa, packDa(6'd7, 6'd7));
      regRead(regCs1, d);
      regRead(regEr1, d);
      waitReady();
      regRead(regDa, d);
      regRead(regEr1, d);
      regWrite(regCs1, goWord(funClear));

      // Reads at random addresses, first ones on the sector and track edge
      for (i = 0; i < 6; i++)
      begin
         r = $random(seed);
         sec = (i < 3) ? lastSector : sectorW'(r[7:0] % 8'd22);
         trk = (i == 1) ? lastTrack : trackW'(r[15:8] % 8'd19);
         cyl = cylW'(r[31:16] % 16'd815);
         regWrite(regDa, packDa(trk, sec));
         regWrite(regDc, 16'(cyl));
         regWrite(regCs1, goWord(funRead));
         waitReady();
         regRead(regDa, d);
         regRead(regDc, d);
         regRead(regEr1, d);
      end

      // Last block of the pack, wraps to zero
      regWrite(regDa, packDa(lastTrack, lastSector));
      regWrite(regDc, 16'(lastCyl));
      regWrite(regCs1, goWord(funRead));
      waitReady();
      regRead(regDa, d);
      regRead(regDc, d);
      regRead(regEr1, d);
      regRead(regDs, d);

      // Let the checker see the last response
      repeat (2) @(posedge clk);
      $display("Reads checked %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== rpDrive.f ====
common/rpPkg.sv
rtl/rpHostPort.sv
drive/rpDriveCtrl.sv
drive/rpAddrRegs.sv
drive/rpErr1.sv
rtl/rpDrive.sv
tb/rpDriveChecker.sv
tb/rpDriveTb.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the rpDrive testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
   --top-module rpDriveTb -Mdir obj_dir -f rpDrive.f
if [ $? -ne 0 ]; then
   echo "Verilator build did not succeed"
   exit 1
fi

./obj_dir/VrpDriveTb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAILED" "$log"; then
   exit 1
fi
exit 0
